//--- hw/rv_isa_pkg.sv
// RV64I subset encodings: widths, opcodes, funct3/funct7 codes and the NOP word
`default_nettype none

package rv_isa_pkg;

    // Datapath and instruction widths
    localparam int XLEN   = 64;           // Data and address width
    localparam int ILEN   = 32;           // Instruction word width
    localparam int OPC_W  = 7;            // Opcode field
    localparam int REG_AW = 5;            // rd/rs1/rs2 fields
    localparam int F3_W   = 3;
    localparam int F7_W   = 7;

    // Major opcodes, bits [6:0]
    localparam logic [OPC_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OP_OPIMM  = 7'b0010011;  // ADDI only here
    localparam logic [OPC_W-1:0] OP_OP     = 7'b0110011;  // ADD / SUB
    localparam logic [OPC_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OP_JAL    = 7'b1101111;

    // funct3 codes of the subset
    localparam logic [F3_W-1:0] F3_ADD = 3'b000;   // ADD, SUB, ADDI
    localparam logic [F3_W-1:0] F3_LB  = 3'b000;
    localparam logic [F3_W-1:0] F3_LD  = 3'b011;
    localparam logic [F3_W-1:0] F3_SD  = 3'b011;
    localparam logic [F3_W-1:0] F3_BEQ = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE = 3'b001;

    // funct7 that turns ADD into SUB
    localparam logic [F7_W-1:0] F7_SUB = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [ILEN-1:0] NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
// Packed structs for fetch packets, data memory requests and retire reports
`default_nettype none

package pipe_pkg;

    // Fetch to queue, 97 bits
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] pc;      // Address the word came from
        logic [rv_isa_pkg::ILEN-1:0] instr;   // Raw instruction word
        logic                        epoch;   // Fetch epoch at request time
    } fetch_pkt_t;

    // Execute to data memory
    typedef struct packed {
        logic                        valid;
        logic                        we;      // 1 = store, 0 = load
        logic [rv_isa_pkg::XLEN-1:0] addr;
        logic [rv_isa_pkg::XLEN-1:0] wdata;   // SD data, full doubleword
    } dmem_req_t;

    // One retired instruction, for the ISA checker
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [rv_isa_pkg::ILEN-1:0]   instr;
        logic [rv_isa_pkg::REG_AW-1:0] rd;
        logic                          rd_we;
        logic [rv_isa_pkg::XLEN-1:0]   rd_data;  // Zero whenever rd is x0
    } retire_t;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
// Fetch stage: PC, credit counter, instruction read issue and redirect epochs
`default_nettype none
`timescale 1ns/1ps

module fetch_stage #(
    parameter int                          QUEUE_DEPTH = 4,
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC    = '0
) (
    input  wire                               clock,
    input  wire                               reset_n,
    output logic                              o_imem_req,
    output logic [rv_isa_pkg::XLEN-1:0]       o_imem_addr,
    input  wire  [rv_isa_pkg::ILEN-1:0]       i_imem_data,
    output logic                              o_push,
    output pipe_pkg::fetch_pkt_t              o_pkt,
    input  wire                               i_credit_ret,
    input  wire                               i_redirect,
    input  wire  [rv_isa_pkg::XLEN-1:0]       i_redirect_pc
);

    localparam int CW = $clog2(QUEUE_DEPTH + 1);  // Holds 0..QUEUE_DEPTH

    logic [CW-1:0]                 credits;    // Free queue slots not yet claimed
    logic [rv_isa_pkg::XLEN-1:0]   pc;         // Next address to request
    logic                          epoch;      // Toggles on every redirect
    logic                          req_epoch;  // Epoch of the request on the bus
    logic                          rsp_valid;  // Word on i_imem_data this cycle
    logic [rv_isa_pkg::XLEN-1:0]   rsp_pc;
    logic                          rsp_epoch;
    logic                          issue;
    logic [rv_isa_pkg::XLEN-1:0]   issue_pc;

    assign issue    = (credits != '0);                    // One credit per request
    assign issue_pc = i_redirect ? i_redirect_pc : pc;    // Redirect wins same cycle

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            credits     <= CW'(QUEUE_DEPTH);
            pc          <= RESET_PC;
            epoch       <= 1'b0;
            o_imem_req  <= 1'b0;
            o_imem_addr <= RESET_PC;
            req_epoch   <= 1'b0;
            rsp_valid   <= 1'b0;
        end else begin
            credits    <= credits - CW'(issue) + CW'(i_credit_ret);
            epoch      <= epoch ^ i_redirect;
            o_imem_req <= issue;
            rsp_valid  <= o_imem_req;         // Word comes back one cycle later
            if (issue) begin
                o_imem_addr <= issue_pc;
                req_epoch   <= epoch ^ i_redirect;  // New path carries new epoch
                pc          <= issue_pc + rv_isa_pkg::XLEN'(4);
            end else if (i_redirect) begin
                pc <= i_redirect_pc;              // Out of credits, just retarget
            end
        end
    end

    // Tag for the word returning next cycle
    always_ff @(posedge clock) begin
        rsp_pc    <= o_imem_addr;
        rsp_epoch <= req_epoch;
    end

    // Push in the data cycle; a stale word keeps its old epoch so its credit comes back
    assign o_push = rsp_valid;
    assign o_pkt  = '{pc: rsp_pc, instr: i_imem_data, epoch: rsp_epoch};

endmodule

`default_nettype wire

//--- hw/inst_queue.sv
// Instruction queue: circular FIFO of fetch packets with one credit back per pop
`default_nettype none
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire                    i_push,
    input  wire pipe_pkg::fetch_pkt_t i_pkt,
    input  wire                    i_pop,
    output pipe_pkg::fetch_pkt_t   o_head,
    output logic                   o_not_empty,
    output logic                   o_credit_ret
);

    localparam int PW = $clog2(QUEUE_DEPTH);      // Pointer width, wraps naturally
    localparam int CW = $clog2(QUEUE_DEPTH + 1);  // Occupancy 0..QUEUE_DEPTH

    pipe_pkg::fetch_pkt_t mem [0:QUEUE_DEPTH-1];
    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        count;
    logic                 do_pop;

    assign o_not_empty = (count != '0);
    assign do_pop      = i_pop && o_not_empty;   // Ignore pops on empty
    assign o_head      = mem[rd_ptr];            // Read-through head

    // Credits guarantee space, so push needs no full check
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            o_credit_ret <= 1'b0;
        end else begin
            wr_ptr       <= wr_ptr + PW'(i_push);
            rd_ptr       <= rd_ptr + PW'(do_pop);
            count        <= count + CW'(i_push) - CW'(do_pop);
            o_credit_ret <= do_pop;              // One credit, cycle after pop
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (i_push) begin
            mem[wr_ptr] <= i_pkt;
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_stage.sv
// Execute stage: decode, register file, add/sub, branches, load/store and retire
`default_nettype none
`timescale 1ns/1ps

module exec_stage (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire pipe_pkg::fetch_pkt_t    i_head,
    input  wire                          i_not_empty,
    output logic                         o_pop,
    output logic                         o_redirect,
    output logic [rv_isa_pkg::XLEN-1:0]  o_redirect_pc,
    output pipe_pkg::dmem_req_t          o_dmem_req,
    input  wire  [rv_isa_pkg::XLEN-1:0]  i_dmem_rdata,
    output pipe_pkg::retire_t            o_retire
);

    localparam int XL    = rv_isa_pkg::XLEN;
    localparam int NREGS = 2 ** rv_isa_pkg::REG_AW;

    logic [XL-1:0]                   regs [0:NREGS-1];
    logic                            epoch;     // Mirrors fetch epoch
    logic                            ld_busy;   // Load waiting for its data
    logic [XL-1:0]                   ld_pc;
    logic [rv_isa_pkg::ILEN-1:0]     ld_instr;
    logic [rv_isa_pkg::ILEN-1:0]     instr;
    logic [XL-1:0]                   pc;
    logic                            live;
    logic [rv_isa_pkg::OPC_W-1:0]    opcode;
    logic [rv_isa_pkg::REG_AW-1:0]   rd;
    logic [rv_isa_pkg::REG_AW-1:0]   rs1;
    logic [rv_isa_pkg::REG_AW-1:0]   rs2;
    logic [rv_isa_pkg::F3_W-1:0]     f3;
    logic [rv_isa_pkg::F7_W-1:0]     f7;
    logic [XL-1:0]                   imm_i;
    logic [XL-1:0]                   imm_s;
    logic [XL-1:0]                   imm_b;
    logic [XL-1:0]                   imm_u;
    logic [XL-1:0]                   imm_j;
    logic [XL-1:0]                   rs1_val;
    logic [XL-1:0]                   rs2_val;
    logic [XL-1:0]                   alu_b;
    logic [XL-1:0]                   alu_res;
    logic                            retire_now;
    logic                            ld_start;
    logic                            wb_we;
    logic [XL-1:0]                   wb_val;

    // Pending load decodes its own saved word, an empty queue decodes a bubble
    assign instr = ld_busy ? ld_instr : (i_not_empty ? i_head.instr : rv_isa_pkg::NOP_WORD);
    assign pc    = ld_busy ? ld_pc : i_head.pc;
    assign o_pop = i_not_empty && !ld_busy;             // Load holds one cycle
    assign live  = o_pop && (i_head.epoch == epoch);    // Stale packets just drain

    // Fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign f3     = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign f7     = instr[31:25];

    // Immediates, all sign-extended to XLEN
    assign imm_i = {{(XL-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XL-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(XL-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{(XL-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(XL-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs1_val = regs[rs1];     // x0 never written, stays zero
    assign rs2_val = regs[rs2];

    // Shared adder: ADD/SUB, ADDI and load address
    assign alu_b   = (opcode == rv_isa_pkg::OP_OP) ? rs2_val : imm_i;
    assign alu_res = ((opcode == rv_isa_pkg::OP_OP) && (f7 == rv_isa_pkg::F7_SUB))
                   ? rs1_val - alu_b : rs1_val + alu_b;

    always_comb begin
        retire_now    = 1'b0;
        ld_start      = 1'b0;
        wb_we         = 1'b0;
        wb_val        = '0;
        o_redirect    = 1'b0;
        o_redirect_pc = pc + imm_b;
        o_dmem_req    = '0;
        if (ld_busy) begin
            retire_now = 1'b1;                        // Data arrived this cycle
            wb_we      = 1'b1;
            if (f3 == rv_isa_pkg::F3_LB) begin
                wb_val = {{(XL-8){i_dmem_rdata[7]}}, i_dmem_rdata[7:0]};
            end else begin
                wb_val = i_dmem_rdata;                // LD
            end
        end else if (live) begin
            retire_now = 1'b1;
            case (opcode)
                rv_isa_pkg::OP_LUI: begin
                    wb_we  = 1'b1;
                    wb_val = imm_u;
                end
                rv_isa_pkg::OP_AUIPC: begin
                    wb_we  = 1'b1;
                    wb_val = pc + imm_u;
                end
                rv_isa_pkg::OP_OPIMM, rv_isa_pkg::OP_OP: begin
                    wb_we  = (f3 == rv_isa_pkg::F3_ADD);
                    wb_val = alu_res;
                end
                rv_isa_pkg::OP_LOAD: begin
                    retire_now      = 1'b0;           // Retires next cycle
                    ld_start        = 1'b1;
                    o_dmem_req.valid = 1'b1;
                    o_dmem_req.addr  = alu_res;
                end
                rv_isa_pkg::OP_STORE: begin
                    o_dmem_req.valid = (f3 == rv_isa_pkg::F3_SD);
                    o_dmem_req.we    = (f3 == rv_isa_pkg::F3_SD);
                    o_dmem_req.addr  = rs1_val + imm_s;
                    o_dmem_req.wdata = rs2_val;
                end
                rv_isa_pkg::OP_BRANCH: begin
                    o_redirect = ((f3 == rv_isa_pkg::F3_BEQ) && (rs1_val == rs2_val))
                              || ((f3 == rv_isa_pkg::F3_BNE) && (rs1_val != rs2_val));
                end
                rv_isa_pkg::OP_JAL: begin
                    wb_we         = 1'b1;
                    wb_val        = pc + XL'(4);      // Link
                    o_redirect    = 1'b1;
                    o_redirect_pc = pc + imm_j;
                end
                default: ;                            // Outside subset, retires as no-op
            endcase
        end
    end

    assign o_retire = '{valid: retire_now, pc: pc, instr: instr, rd: rd, rd_we: wb_we,
                        rd_data: (wb_we && (rd != '0)) ? wb_val : '0};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            epoch   <= 1'b0;
            ld_busy <= 1'b0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            epoch   <= epoch ^ o_redirect;            // Same toggle as fetch
            ld_busy <= ld_start;
            if (retire_now && wb_we && (rd != '0)) begin
                regs[rd] <= wb_val;                   // x0 stays zero
            end
        end
    end

    // Saved load context
    always_ff @(posedge clock) begin
        if (ld_start) begin
            ld_pc    <= pc;
            ld_instr <= instr;
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
// Core top: fetch stage, instruction queue and execute stage
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
    parameter int                          QUEUE_DEPTH = 4,
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC    = '0
) (
    input  wire                               clock,
    input  wire                               reset_n,
    output wire                               o_imem_req,
    output wire  [rv_isa_pkg::XLEN-1:0]       o_imem_addr,
    input  wire  [rv_isa_pkg::ILEN-1:0]       i_imem_data,
    output pipe_pkg::dmem_req_t               o_dmem_req,
    input  wire  [rv_isa_pkg::XLEN-1:0]       i_dmem_rdata,
    output pipe_pkg::retire_t                 o_retire
);

    wire pipe_pkg::fetch_pkt_t         fetch_pkt;     // Fetch to queue
    wire pipe_pkg::fetch_pkt_t         queue_head;    // Queue to execute
    wire                               push;
    wire                               credit_ret;
    wire                               not_empty;
    wire                               pop;
    wire                               redirect;
    wire [rv_isa_pkg::XLEN-1:0]        redirect_pc;

    fetch_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) fetch_stage_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .i_imem_data   (i_imem_data),
        .o_push        (push),
        .o_pkt         (fetch_pkt),
        .i_credit_ret  (credit_ret),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) inst_queue_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .i_push       (push),
        .i_pkt        (fetch_pkt),
        .i_pop        (pop),
        .o_head       (queue_head),
        .o_not_empty  (not_empty),
        .o_credit_ret (credit_ret)
    );

    exec_stage exec_stage_inst (
        .clock         (clock),
        .reset_n       (reset_n),
        .i_head        (queue_head),
        .i_not_empty   (not_empty),
        .o_pop         (pop),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_dmem_req    (o_dmem_req),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_retire      (o_retire)
    );

endmodule

`default_nettype wire

//--- tests/rv_core_chk.sv
// Bound assertions on credits, queue occupancy, register x0 and data requests in reset
`default_nettype none
`timescale 1ns/1ps

module rv_core_chk #(
    parameter int QUEUE_DEPTH = 4
) (
    input wire                                 clock,
    input wire                                 reset_n,
    input wire [$clog2(QUEUE_DEPTH + 1)-1:0]   i_credits,
    input wire [$clog2(QUEUE_DEPTH + 1)-1:0]   i_count,
    input wire                                 i_push,
    input wire [rv_isa_pkg::XLEN-1:0]          i_x0,
    input wire                                 i_dmem_valid
);

    localparam int                CW   = $clog2(QUEUE_DEPTH + 1);
    localparam logic [CW-1:0]     FULL = CW'(QUEUE_DEPTH);

    credit_limit: assert property (@(posedge clock) disable iff (!reset_n)
        i_credits <= FULL)
        else $error("credit count above queue depth");

    no_push_full: assert property (@(posedge clock) disable iff (!reset_n)
        (i_count == FULL) |-> !i_push)
        else $error("push into a full instruction queue");

    // Register file entry 0 never takes a retirement write
    x0_stays_zero: assert property (@(posedge clock) disable iff (!reset_n)
        i_x0 == '0)
        else $error("register x0 holds a nonzero value");

    // Active while reset is held
    dmem_quiet_reset: assert property (@(posedge clock)
        !reset_n |-> !i_dmem_valid)
        else $error("data request while reset is asserted");

endmodule

bind rv_core rv_core_chk #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) rv_core_chk_inst (
    .clock        (clock),
    .reset_n      (reset_n),
    .i_credits    (fetch_stage_inst.credits),
    .i_count      (inst_queue_inst.count),
    .i_push       (push),
    .i_x0         (exec_stage_inst.regs[0]),
    .i_dmem_valid (o_dmem_req.valid)
);

`default_nettype wire

//--- tests/tb_rv_core.sv
// rv_core testbench with random program, memory models, ISA reference model and checks
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          QUEUE_DEPTH = 4;
    localparam logic [63:0] RESET_PC    = 64'h0;
    localparam int          NUM_INSTR   = 64;
    localparam int          NUM_DWORDS  = 32;
    localparam logic [63:0] DATA_BASE   = 64'h400;    // 256-byte aligned and clear of code
    localparam logic [63:0] DATA_END    = DATA_BASE + 64'(NUM_DWORDS * 8);
    localparam int          TIMEOUT     = 5000;       // Cycles allowed per wait

    // Instruction kinds shared by generator and model
    localparam int K_LUI   = 0;
    localparam int K_AUIPC = 1;
    localparam int K_ADDI  = 2;
    localparam int K_ADD   = 3;
    localparam int K_SUB   = 4;
    localparam int K_LB    = 5;
    localparam int K_LD    = 6;
    localparam int K_SD    = 7;
    localparam int K_BEQ   = 8;
    localparam int K_BNE   = 9;
    localparam int K_JAL   = 10;

    logic                clock = 1'b0;
    logic                reset_n;
    logic                imem_req;
    logic [63:0]         imem_addr;
    logic [31:0]         imem_data;
    pipe_pkg::dmem_req_t dmem_req;
    logic [63:0]         dmem_rdata;
    pipe_pkg::retire_t   retire;

    // Program image plus its meaning for the model
    logic [31:0] prog   [0:NUM_INSTR-1];
    int          kind_of[0:NUM_INSTR-1];
    logic [4:0]  rd_of  [0:NUM_INSTR-1];
    logic [4:0]  rs1_of [0:NUM_INSTR-1];
    logic [4:0]  rs2_of [0:NUM_INSTR-1];
    logic [63:0] imm_of [0:NUM_INSTR-1];      // Sign-extended immediate or branch/jump offset

    logic [63:0] dmem      [0:NUM_DWORDS-1];  // Memory seen by the DUT
    logic [63:0] model_mem [0:NUM_DWORDS-1];  // Memory after the model run

    // Expected retire list and store list
    logic [63:0] exp_pc[$];
    logic [31:0] exp_instr[$];
    logic [4:0]  exp_rd[$];
    logic        exp_we[$];
    logic [63:0] exp_data[$];
    logic [63:0] exp_st_addr[$];
    logic [63:0] exp_st_data[$];
    int          ret_idx = 0;
    int          st_idx  = 0;

    rv_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) rv_core_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .o_dmem_req   (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    always #20 clock = ~clock;                // 40 ns period

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Base encodings
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [6:0] op);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd, logic [6:0] op);
        return {off[20], off[10:1], off[11], off[19:12], rd, op};
    endfunction

    function automatic logic [31:0] fetch_word(logic [63:0] addr);
        logic [63:0] offset;
        offset = addr - RESET_PC;
        if (offset >= 64'(NUM_INSTR * 4)) begin
            return rv_isa_pkg::NOP_WORD;      // Run-ahead past the last word
        end
        return prog[offset[7:2]];
    endfunction

    // Pattern built from the full byte address
    task automatic fill_data();
        logic [63:0] addr;
        for (int s = 0; s < NUM_DWORDS; s++) begin
            addr         = DATA_BASE + 64'(s * 8);
            dmem[s]      = (addr * 64'h9E37_79B9_7F4A_7C15) ^ (addr << 40);
            model_mem[s] = dmem[s];
        end
    endtask

    task automatic gen_program();
        int          kind;
        int          span;
        int          slot;
        logic [11:0] imm12;
        logic [11:0] mem_imm;
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        for (int i = 0; i < NUM_INSTR; i++) begin
            kind    = int'($urandom_range(0, 15));
            rd      = 5'($urandom_range(0, 7));   // Few registers give more equal compares
            rs1     = 5'($urandom_range(0, 7));
            rs2     = 5'($urandom_range(0, 7));
            imm12   = 12'($urandom);
            imm20   = 20'($urandom);
            slot    = int'($urandom_range(0, NUM_DWORDS - 1));
            mem_imm = 12'(DATA_BASE) + 12'(slot * 8);
            span    = int'($urandom_range(1, 8));  // Forward distance in words
            if (i + span > NUM_INSTR - 1) begin
                span = NUM_INSTR - 1 - i;
            end
            if (i == NUM_INSTR - 1) begin
                kind = 15;                        // Final JAL x0 to itself
                rd   = '0;
            end
            rd_of[i]  = rd;
            rs1_of[i] = rs1;
            rs2_of[i] = rs2;
            imm_of[i] = {{52{imm12[11]}}, imm12};
            case (kind)
                0, 1: begin
                    kind_of[i] = K_LUI;
                    imm_of[i]  = {{32{imm20[19]}}, imm20, 12'b0};
                    prog[i]    = {imm20, rd, rv_isa_pkg::OP_LUI};
                end
                2: begin
                    kind_of[i] = K_AUIPC;
                    imm_of[i]  = {{32{imm20[19]}}, imm20, 12'b0};
                    prog[i]    = {imm20, rd, rv_isa_pkg::OP_AUIPC};
                end
                3, 4, 5: begin
                    kind_of[i] = K_ADDI;
                    prog[i] = enc_i(imm12, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_OPIMM);
                end
                6, 7: begin
                    kind_of[i] = K_ADD;
                    prog[i] = enc_r(7'b0, rs2, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_OP);
                end
                8: begin
                    kind_of[i] = K_SUB;
                    prog[i] = enc_r(rv_isa_pkg::F7_SUB, rs2, rs1, rv_isa_pkg::F3_ADD, rd,
                                    rv_isa_pkg::OP_OP);
                end
                9, 10: begin                      // Loads off x0
                    kind_of[i] = (kind == 9) ? K_LB : K_LD;
                    rs1_of[i]  = '0;
                    imm_of[i]  = {52'b0, mem_imm};
                    prog[i]    = enc_i(mem_imm, 5'd0,
                                       (kind == 9) ? rv_isa_pkg::F3_LB : rv_isa_pkg::F3_LD,
                                       rd, rv_isa_pkg::OP_LOAD);
                end
                11, 12: begin
                    kind_of[i] = K_SD;
                    rs1_of[i]  = '0;
                    imm_of[i]  = {52'b0, mem_imm};
                    prog[i] = enc_s(mem_imm, rs2, 5'd0, rv_isa_pkg::F3_SD, rv_isa_pkg::OP_STORE);
                end
                13, 14: begin
                    kind_of[i] = (kind == 13) ? K_BEQ : K_BNE;
                    imm_of[i]  = 64'(span * 4);
                    prog[i]    = enc_b(13'(span * 4), rs2, rs1,
                                       (kind == 13) ? rv_isa_pkg::F3_BEQ : rv_isa_pkg::F3_BNE,
                                       rv_isa_pkg::OP_BRANCH);
                end
                default: begin
                    kind_of[i] = K_JAL;
                    imm_of[i]  = 64'(span * 4);
                    prog[i]    = enc_j(21'(span * 4), rd, rv_isa_pkg::OP_JAL);
                end
            endcase
        end
    endtask

    // Sequential ISA model that runs until the JAL to itself
    task automatic run_model();
        logic [63:0] mregs [0:31];
        logic [63:0] pc;
        logic [63:0] next_pc;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] val;
        logic        we;
        logic        done;
        int          i;
        int          slot;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        pc   = RESET_PC;
        done = 1'b0;
        while (!done) begin
            i       = int'((pc - RESET_PC) >> 2);
            a       = mregs[rs1_of[i]];
            b       = mregs[rs2_of[i]];
            we      = 1'b1;
            val     = '0;
            next_pc = pc + 64'd4;
            slot    = int'((imm_of[i] - DATA_BASE) >> 3);
            case (kind_of[i])
                K_LUI:   val = imm_of[i];
                K_AUIPC: val = pc + imm_of[i];
                K_ADDI:  val = a + imm_of[i];
                K_ADD:   val = a + b;
                K_SUB:   val = a - b;
                K_LB:    val = {{56{model_mem[slot][7]}}, model_mem[slot][7:0]};
                K_LD:    val = model_mem[slot];
                K_SD: begin
                    we              = 1'b0;
                    model_mem[slot] = b;
                    exp_st_addr.push_back(imm_of[i]);
                    exp_st_data.push_back(b);
                end
                K_BEQ, K_BNE: begin
                    we = 1'b0;
                    if ((a == b) == (kind_of[i] == K_BEQ)) begin
                        next_pc = pc + imm_of[i];  // Taken
                    end
                end
                K_JAL: begin
                    val     = pc + 64'd4;           // Link
                    next_pc = pc + imm_of[i];
                    done    = (next_pc == pc);
                end
                default: ;
            endcase
            if (we && (rd_of[i] != 5'd0)) begin
                mregs[rd_of[i]] = val;
            end
            exp_pc.push_back(pc);
            exp_instr.push_back(prog[i]);
            exp_rd.push_back(prog[i][11:7]);      // Raw field that holds imm bits for S/B
            exp_we.push_back(we);
            exp_data.push_back((we && (rd_of[i] != 5'd0)) ? val : 64'd0);
            pc = next_pc;
        end
    endtask

    // Memory models with one-cycle read data
    always @(posedge clock) begin
        if (imem_req) begin
            imem_data <= fetch_word(imem_addr);
        end
        if (dmem_req.valid) begin
            if (dmem_req.we) begin
                dmem[dmem_req.addr[7:3]] <= dmem_req.wdata;  // Low bits index the region
            end else begin
                dmem_rdata <= dmem[dmem_req.addr[7:3]];
            end
        end
    end

    // Retire and store monitor
    always @(posedge clock) begin
        if (reset_n) begin
            if (retire.valid && (ret_idx < exp_pc.size())) begin
                compare_value("retire.pc", retire.pc, exp_pc[ret_idx]);
                compare_value("retire.instr", 64'(retire.instr), 64'(exp_instr[ret_idx]));
                compare_value("retire.rd", 64'(retire.rd), 64'(exp_rd[ret_idx]));
                compare_value("retire.rd_we", 64'(retire.rd_we), 64'(exp_we[ret_idx]));
                compare_value("retire.rd_data", retire.rd_data, exp_data[ret_idx]);
                ret_idx <= ret_idx + 1;
            end
            if (dmem_req.valid) begin
                if ((dmem_req.addr < DATA_BASE) || (dmem_req.addr >= DATA_END)
                    || (dmem_req.addr[2:0] != 3'b0)) begin
                    abort_run("data access outside the aligned data region");
                end else if (dmem_req.we && (st_idx >= exp_st_addr.size())) begin
                    abort_run("more stores issued than the program performs");
                end else if (dmem_req.we) begin
                    compare_value("dmem_req.addr", dmem_req.addr, exp_st_addr[st_idx]);
                    compare_value("dmem_req.wdata", dmem_req.wdata, exp_st_data[st_idx]);
                    st_idx <= st_idx + 1;
                end
            end
        end
    end

    task automatic wait_first_fetch();
        int cycles;
        cycles = 0;
        while (!imem_req) begin
            @(negedge clock);                 // Fetch outputs settled mid-cycle
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timed out waiting for the first instruction fetch");
            end
        end
        compare_value("imem_addr", imem_addr, RESET_PC);
    endtask

    task automatic wait_program_end();
        int cycles;
        cycles = 0;
        while (ret_idx < exp_pc.size()) begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timed out waiting for the program to retire");
            end
        end
    endtask

    initial begin
        reset_n    = 1'b0;
        imem_data  = rv_isa_pkg::NOP_WORD;
        dmem_rdata = '0;
        void'($urandom(90));
        fill_data();
        gen_program();
        run_model();
        repeat (5) begin                      // Fetch stays quiet in reset
            @(posedge clock);
            compare_value("imem_req", 64'(imem_req), 64'd0);
        end
        reset_n <= 1'b1;
        wait_first_fetch();
        wait_program_end();
        compare_value("store count", 64'(st_idx), 64'(exp_st_addr.size()));
        for (int s = 0; s < NUM_DWORDS; s++) begin
            compare_value($sformatf("dmem[%0d]", s), dmem[s], model_mem[s]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_stage.sv
hw/inst_queue.sv
hw/exec_stage.sv
hw/rv_core.sv
tests/rv_core_chk.sv
tests/tb_rv_core.sv

//--- Makefile
# Verilator flow for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
